//--- common/arp_pkg.sv
`default_nettype none

package arp_pkg;

  // Frame framing
  localparam int preamble_bytes = 7;
  localparam logic [7:0] preamble_byte = 8'h55;
  localparam logic [7:0] sfd_byte = 8'hD5;

  // Bytes after the SFD up to the FCS, padded to the Ethernet minimum
  localparam logic [5:0] body_bytes = 6'd60;
  localparam int fcs_bytes = 4;

  // Idle cycles between frames
  localparam int ifg_bytes = 12;

  // Ethernet header
  localparam logic [15:0] eth_type_arp = 16'h0806;

  // ARP request fields
  localparam logic [15:0] arp_htype_eth = 16'h0001;    // Ethernet hardware
  localparam logic [15:0] arp_ptype_ipv4 = 16'h0800;   // IPv4 protocol
  localparam logic [7:0] arp_hlen = 8'h06;
  localparam logic [7:0] arp_plen = 8'h04;
  localparam logic [15:0] arp_oper_request = 16'h0001;

  // CRC-32 as used by the Ethernet FCS, LSB first on the wire
  localparam logic [31:0] crc32_poly_reflected = 32'hEDB88320;
  localparam logic [31:0] crc32_init = 32'hFFFFFFFF;

  // FCS seen as one word by the CRC logic and as wire bytes by the sequencer
  typedef union packed {
    logic [31:0] word;
    logic [3:0][7:0] bytes;                            // Byte 0 goes out first
  } fcs_word_u;

endpackage

`default_nettype wire

//--- common/crc_if.sv
`timescale 1ns/1ps
`default_nettype none

interface crc_if;

  logic clear;                  // Reload the register with the init value
  logic update;                 // Fold data in on this cycle
  logic [7:0] data;             // Byte currently on its way to the PHY
  arp_pkg::fcs_word_u fcs;      // Complemented register value

  modport crc_gen (
    input  clear,
    input  update,
    input  data,
    output fcs
  );

  modport crc_user (
    output clear,
    output update,
    output data,
    input  fcs
  );

endinterface

`default_nettype wire

//--- verilog/arp_field_mux.sv
`timescale 1ns/1ps
`default_nettype none

module arp_field_mux #(
  parameter logic [47:0] src_mac = 48'h0,
  parameter logic [31:0] src_ip = 32'h0,
  parameter logic [31:0] dst_ip = 32'h0
) (
  input  wire  [5:0] byte_index,
  output logic [7:0] field_byte
);

  // Byte of the source MAC, offset 0 is the most significant byte
  function automatic logic [7:0] mac_byte(input logic [5:0] off);
    return src_mac[(5 - off) * 8 +: 8];
  endfunction

  // Byte of an IPv4 address, offset 0 is the most significant byte
  function automatic logic [7:0] ip_byte(input logic [31:0] ip, input logic [5:0] off);
    return ip[(3 - off) * 8 +: 8];
  endfunction

  // 16-bit fields all start on even offsets
  function automatic logic [7:0] half_byte(input logic [15:0] value, input logic odd);
    return odd ? value[7:0] : value[15:8];
  endfunction

  always_comb
  begin
    field_byte = 8'h00;
    case (byte_index) inside
      [6'd0:6'd5]:
      begin
        field_byte = 8'hFF;                                       // Broadcast destination
      end
      [6'd6:6'd11]:
      begin
        field_byte = mac_byte(byte_index - 6'd6);                 // Ethernet source
      end
      [6'd12:6'd13]:
      begin
        field_byte = half_byte(arp_pkg::eth_type_arp, byte_index[0]);
      end
      [6'd14:6'd15]:
      begin
        field_byte = half_byte(arp_pkg::arp_htype_eth, byte_index[0]);
      end
      [6'd16:6'd17]:
      begin
        field_byte = half_byte(arp_pkg::arp_ptype_ipv4, byte_index[0]);
      end
      6'd18:
      begin
        field_byte = arp_pkg::arp_hlen;
      end
      6'd19:
      begin
        field_byte = arp_pkg::arp_plen;
      end
      [6'd20:6'd21]:
      begin
        field_byte = half_byte(arp_pkg::arp_oper_request, byte_index[0]);
      end
      [6'd22:6'd27]:
      begin
        field_byte = mac_byte(byte_index - 6'd22);                // Sender hardware address
      end
      [6'd28:6'd31]:
      begin
        field_byte = ip_byte(src_ip, byte_index - 6'd28);         // Sender protocol address
      end
      [6'd32:6'd37]:
      begin
        field_byte = 8'h00;                                       // Target MAC unknown
      end
      [6'd38:6'd41]:
      begin
        field_byte = ip_byte(dst_ip, byte_index - 6'd38);         // Target protocol address
      end
      default:
      begin
        field_byte = 8'h00;                                       // Padding to 60 bytes
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/eth_crc32.sv
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 (
  input  wire    tx_clk,
  input  wire    arst_n,
  crc_if.crc_gen crc
);

  logic [31:0] crc_q;
  logic [31:0] crc_next;

  // One byte per cycle, bit 0 of the data enters first
  always_comb
  begin
    crc_next = crc_q ^ {24'h000000, crc.data};
    for (int bit_i = 0; bit_i < 8; bit_i++)
    begin
      if (crc_next[0])
      begin
        crc_next = (crc_next >> 1) ^ arp_pkg::crc32_poly_reflected;
      end
      else
      begin
        crc_next = crc_next >> 1;
      end
    end
  end

  always_ff @(posedge tx_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      crc_q <= arp_pkg::crc32_init;
    end
    else if (crc.clear)                       // Clear wins over update
    begin
      crc_q <= arp_pkg::crc32_init;
    end
    else if (crc.update)
    begin
      crc_q <= crc_next;
    end
  end

  // Low byte of the inverted register is the first FCS byte on the wire
  assign crc.fcs.word = ~crc_q;

endmodule

`default_nettype wire

//--- verilog/eth_tx_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module eth_tx_sequencer (
  input  wire        tx_clk,
  input  wire        arst_n,
  input  wire        send,
  output logic [5:0] byte_index,
  input  wire  [7:0] field_byte,
  crc_if.crc_user    crc,
  output logic       tx_en,
  output logic [3:0] tx_data_lo,
  output logic [3:0] tx_data_hi
);

  localparam logic [2:0] st_idle = 3'd0;
  localparam logic [2:0] st_pre = 3'd1;
  localparam logic [2:0] st_sfd = 3'd2;
  localparam logic [2:0] st_body = 3'd3;
  localparam logic [2:0] st_fcs = 3'd4;
  localparam logic [2:0] st_gap = 3'd5;

  logic [2:0] state_q;
  logic [2:0] state_d;
  logic [5:0] cnt_q;                          // Shared byte counter for every phase
  logic [5:0] cnt_d;
  logic       sending;
  logic [7:0] tx_byte;

  always_comb
  begin
    state_d = state_q;
    cnt_d = cnt_q + 6'd1;
    case (state_q)
      st_idle:
      begin
        cnt_d = 6'd0;
        if (send)
        begin
          state_d = st_pre;
        end
      end
      st_pre:
      begin
        if (cnt_q == arp_pkg::preamble_bytes - 1)
        begin
          state_d = st_sfd;
          cnt_d = 6'd0;
        end
      end
      st_sfd:
      begin
        state_d = st_body;
        cnt_d = 6'd0;
      end
      st_body:
      begin
        if (cnt_q == arp_pkg::body_bytes - 6'd1)
        begin
          state_d = st_fcs;
          cnt_d = 6'd0;
        end
      end
      st_fcs:
      begin
        if (cnt_q == arp_pkg::fcs_bytes - 1)
        begin
          state_d = st_gap;
          cnt_d = 6'd0;
        end
      end
      st_gap:
      begin
        if (cnt_q == arp_pkg::ifg_bytes - 1)  // Send sampled on the last gap cycle
        begin
          state_d = send ? st_pre : st_idle;
          cnt_d = 6'd0;
        end
      end
      default:
      begin
        state_d = st_idle;
        cnt_d = 6'd0;
      end
    endcase
  end

  always_ff @(posedge tx_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q <= st_idle;
      cnt_q <= 6'd0;
    end
    else
    begin
      state_q <= state_d;
      cnt_q <= cnt_d;
    end
  end

  // Byte for the current phase, zero outside a frame
  always_comb
  begin
    case (state_q)
      st_pre:  tx_byte = arp_pkg::preamble_byte;
      st_sfd:  tx_byte = arp_pkg::sfd_byte;
      st_body: tx_byte = field_byte;
      st_fcs:  tx_byte = crc.fcs.bytes[cnt_q[1:0]];
      default: tx_byte = 8'h00;
    endcase
  end

  assign sending = (state_q == st_pre) || (state_q == st_sfd) ||
                   (state_q == st_body) || (state_q == st_fcs);

  assign byte_index = cnt_q;
  assign crc.clear = (state_q == st_sfd);      // Fresh CRC before the first body byte
  assign crc.update = (state_q == st_body);
  assign crc.data = field_byte;

  always_ff @(posedge tx_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tx_en <= 1'b0;
      tx_data_lo <= 4'h0;
      tx_data_hi <= 4'h0;
    end
    else
    begin
      tx_en <= sending;
      tx_data_lo <= tx_byte[3:0];
      tx_data_hi <= tx_byte[7:4];
    end
  end

endmodule

`default_nettype wire

//--- verilog/arp_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module arp_tx_top #(
  parameter logic [47:0] src_mac = 48'hAC162D0B5AA2,
  parameter logic [31:0] src_ip = 32'hC0A80090,       // 192.168.0.144
  parameter logic [31:0] dst_ip = 32'hC0A800A6        // 192.168.0.166
) (
  input  wire       tx_clk,
  input  wire       arst_n,
  input  wire       send,
  output wire       tx_en,
  output wire [3:0] tx_data_lo,
  output wire [3:0] tx_data_hi
);

  wire [5:0] byte_index;
  wire [7:0] field_byte;

  crc_if crc_link ();

  arp_field_mux #(
    .src_mac (src_mac),
    .src_ip  (src_ip),
    .dst_ip  (dst_ip)
  ) field_mux_i (
    .byte_index (byte_index),
    .field_byte (field_byte)
  );

  eth_crc32 crc_i (
    .tx_clk (tx_clk),
    .arst_n (arst_n),
    .crc    (crc_link.crc_gen)
  );

  eth_tx_sequencer seq_i (
    .tx_clk     (tx_clk),
    .arst_n     (arst_n),
    .send       (send),
    .byte_index (byte_index),
    .field_byte (field_byte),
    .crc        (crc_link.crc_user),
    .tx_en      (tx_en),
    .tx_data_lo (tx_data_lo),
    .tx_data_hi (tx_data_hi)
  );

endmodule

`default_nettype wire

//--- verification/arp_tx_model.svh
`ifndef ARP_TX_MODEL_SVH
`define ARP_TX_MODEL_SVH

// Expected byte at a body offset after the SFD
function automatic logic [7:0] expected_body_byte(input int idx);
  logic [335:0] header;
  header = {48'hFFFF_FFFF_FFFF, src_mac, arp_pkg::eth_type_arp,
            arp_pkg::arp_htype_eth, arp_pkg::arp_ptype_ipv4,
            arp_pkg::arp_hlen, arp_pkg::arp_plen, arp_pkg::arp_oper_request,
            src_mac, src_ip, 48'h0000_0000_0000, dst_ip};
  if (idx < 42)
  begin
    return header[335 - idx * 8 -: 8];
  end
  return 8'h00;                                   // Zero padding
endfunction

// Bit-serial CRC-32 over the expected body, data LSB first
function automatic logic [31:0] expected_fcs();
  logic [31:0] crc_reg;
  logic [7:0] data;
  logic feedback;
  crc_reg = 32'hFFFF_FFFF;
  for (int i = 0; i < 60; i++)
  begin
    data = expected_body_byte(i);
    for (int k = 0; k < 8; k++)
    begin
      feedback = crc_reg[0] ^ data[k];
      crc_reg = crc_reg >> 1;
      if (feedback)
      begin
        crc_reg = crc_reg ^ 32'hEDB8_8320;
      end
    end
  end
  return ~crc_reg;                                // Low byte goes out first
endfunction

`endif

//--- verification/arp_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module arp_tx_tb;

  localparam logic [47:0] src_mac = 48'hAC162D0B5AA2;
  localparam logic [31:0] src_ip = 32'hC0A80090;
  localparam logic [31:0] dst_ip = 32'hC0A800A6;
  localparam int frame_bytes = 72;
  localparam int gap_cycles = 12;
  localparam int wait_limit = 500;

  logic tx_clk;
  logic arst_n;
  logic send;
  wire tx_en;
  wire [3:0] tx_data_lo;
  wire [3:0] tx_data_hi;

  int errors = 0;
  int timeouts = 0;
  int frames_started = 0;
  int frames_done = 0;
  int low_len = 0;
  bit expect_gap = 1'b0;                          // Gap length checked at next frame start
  logic [7:0] frame_q[$];

  `include "arp_tx_model.svh"

  arp_tx_top #(
    .src_mac (src_mac),
    .src_ip  (src_ip),
    .dst_ip  (dst_ip)
  ) dut_i (
    .tx_clk     (tx_clk),
    .arst_n     (arst_n),
    .send       (send),
    .tx_en      (tx_en),
    .tx_data_lo (tx_data_lo),
    .tx_data_hi (tx_data_hi)
  );

  initial
  begin
    tx_clk = 1'b0;
    forever #5 tx_clk = ~tx_clk;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    assert (got === exp)
    else
    begin
      errors++;
      $display("Fail %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_frame();
    logic [31:0] fcs;
    fcs = expected_fcs();
    check_value(frame_q.size(), frame_bytes, "frame length");
    if (frame_q.size() == frame_bytes)
    begin
      for (int i = 0; i < 7; i++)
      begin
        check_value(frame_q[i], 8'h55, $sformatf("preamble byte %0d", i));
      end
      check_value(frame_q[7], 8'hD5, "SFD");
      for (int i = 0; i < 60; i++)
      begin
        check_value(frame_q[8 + i], expected_body_byte(i), $sformatf("body byte %0d", i));
      end
      for (int k = 0; k < 4; k++)
      begin
        check_value(frame_q[68 + k], fcs[k * 8 +: 8], $sformatf("FCS byte %0d", k));
      end
    end
  endtask

  // Frame capture, sampled away from the driving edge
  always @(negedge tx_clk)
  begin
    if (!tx_en)
    begin
      check_value(tx_data_lo, 4'h0, "tx_data_lo while tx_en low");
      check_value(tx_data_hi, 4'h0, "tx_data_hi while tx_en low");
    end
    if (!arst_n)
    begin
      check_value(tx_en, 1'b0, "tx_en during reset");
      frame_q.delete();                           // Aborted frame is dropped
      low_len = 0;
    end
    else if (tx_en)
    begin
      if (frame_q.size() == 0)
      begin
        frames_started++;
        if (expect_gap)
        begin
          check_value(low_len, gap_cycles, "idle cycles between frames");
        end
      end
      frame_q.push_back({tx_data_hi, tx_data_lo});
    end
    else
    begin
      if (frame_q.size() != 0)
      begin
        check_frame();
        frames_done++;
        frame_q.delete();
        low_len = 0;
      end
      low_len++;
    end
  end

  task automatic wait_started(input int target);
    int n;
    n = 0;
    while (frames_started < target && n < wait_limit)
    begin
      @(posedge tx_clk);
      n++;
    end
    if (frames_started < target)
    begin
      timeouts++;
      $display("Timeout at %0t: tx_en never rose for frame %0d", $time, target);
    end
  endtask

  task automatic wait_done(input int target);
    int n;
    n = 0;
    while (frames_done < target && n < wait_limit)
    begin
      @(posedge tx_clk);
      n++;
    end
    if (frames_done < target)
    begin
      timeouts++;
      $display("Timeout at %0t: tx_en never fell after frame %0d", $time, target);
    end
  endtask

  initial
  begin
    int idle_cycles;
    int drop_at;
    void'($urandom(14894));
    arst_n = 1'b0;
    send = 1'b0;
    repeat (8) @(posedge tx_clk);
    arst_n <= 1'b1;

    idle_cycles = $urandom_range(20, 5);          // Idle with send low
    repeat (idle_cycles) @(posedge tx_clk);
    check_value(frames_started, 0, "frames started with send low");

    send <= 1'b1;                                 // Send dropped inside a frame
    wait_started(1);
    drop_at = $urandom_range(70, 1);
    repeat (drop_at) @(posedge tx_clk);
    send <= 1'b0;
    wait_done(1);
    repeat (gap_cycles + 40) @(posedge tx_clk);
    check_value(frames_started, 1, "frames started after send dropped");

    idle_cycles = $urandom_range(20, 1);          // Three back-to-back frames
    repeat (idle_cycles) @(posedge tx_clk);
    send <= 1'b1;
    wait_started(2);
    expect_gap = 1'b1;
    wait_done(2);
    wait_started(3);
    wait_done(3);
    wait_started(4);
    send <= 1'b0;
    expect_gap = 1'b0;
    wait_done(4);
    repeat (gap_cycles + 40) @(posedge tx_clk);
    check_value(frames_started, 4, "frames started after held send");

    send <= 1'b1;                                 // Reset in the middle of a frame
    wait_started(5);
    drop_at = $urandom_range(60, 5);
    repeat (drop_at) @(posedge tx_clk);
    arst_n <= 1'b0;
    #1;
    check_value(tx_en, 1'b0, "tx_en right after reset");
    check_value(tx_data_lo, 4'h0, "tx_data_lo right after reset");
    check_value(tx_data_hi, 4'h0, "tx_data_hi right after reset");
    repeat (8) @(posedge tx_clk);
    arst_n <= 1'b1;
    wait_started(6);
    send <= 1'b0;
    wait_done(5);
    repeat (20) @(posedge tx_clk);

    $display("Errors: %0d value mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+verification
common/arp_pkg.sv
common/crc_if.sv
verilog/arp_field_mux.sv
verilog/eth_crc32.sv
verilog/eth_tx_sequencer.sv
verilog/arp_tx_top.sv
verification/arp_tx_tb.sv

//--- Bender.yml
package:
  name: arp_tx

sources:
  # Shared package and interface
  - common/arp_pkg.sv
  - common/crc_if.sv
  # RTL
  - verilog/arp_field_mux.sv
  - verilog/eth_crc32.sv
  - verilog/eth_tx_sequencer.sv
  - verilog/arp_tx_top.sv
  # Testbench
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/arp_tx_tb.sv
